// ==== common/copper_pkg.sv ====
//--------------------------------------------------------------------------
// Copper shared definitions: opcodes, FSM states, XR address map,
// video frame totals and the XR write bus type
//--------------------------------------------------------------------------
package copper_pkg;

    // Bus and word widths
    localparam int XR_ADDR_W = 16;
    localparam int DATA_W    = 16;

    // Beam coordinates and program counter
    localparam int POS_W = 11;
    // 2K words of copper memory
    localparam int PC_W  = 11;

    // XR address map
    localparam logic [XR_ADDR_W-1:0] XR_COPP_CTRL  = 16'h0001;
    localparam logic [XR_ADDR_W-1:0] XR_COLOR_MEM  = 16'h8000;
    // 256 color entries
    localparam int                   COLOR_ADDR_W  = 8;
    localparam logic [XR_ADDR_W-1:0] XR_COPPER_MEM = 16'hC000;

    // Frame size in pixels and lines, blanking included
    localparam int H_TOTAL = 800;
    localparam int V_TOTAL = 525;

    // Restart point sits a few pixels before the end of the last line
    localparam int RESTART_H_OFFSET = 5;

    // Control register layout
    // [15] enable, [10:0] initial PC
    localparam int CTRL_EN_BIT = 15;

    // WAIT and SKIP flag bits in the low nibble of the second word
    localparam int FLAG_IGNORE_V = 0;
    localparam int FLAG_IGNORE_H = 1;

    // Opcodes in the top nibble of the first word
    // Anything not listed runs as a no-op
    typedef enum logic [3:0] {
        OP_WAIT  = 4'b0000,
        OP_SKIP  = 4'b0010,
        OP_JMP   = 4'b0100,
        OP_MOVER = 4'b1001,
        OP_MOVEP = 4'b1011,
        OP_MOVEC = 4'b1100
    } insn_op_t;

    // Fetch and execute states
    typedef enum logic [2:0] {
        // Prefetch of the first word, only after enable or restart
        ST_INIT   = 3'd0,
        // Memory latency, PC moves to the second word
        ST_WAIT   = 3'd1,
        ST_LATCH1 = 3'd2,
        ST_LATCH2 = 3'd3,
        // Execute, also kicks off the next fetch
        ST_EXEC   = 3'd4
    } copper_state_t;

    // One registered write on the shared XR bus
    typedef struct packed {
        logic                 wr_en;
        logic [XR_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]    data;
    } xr_wr_t;

endpackage

// ==== common/xr_wr_if.sv ====
//--------------------------------------------------------------------------
// Write request and grant between the copper core and the XR arbiter
//--------------------------------------------------------------------------
`timescale 1ns/1ps

interface xr_wr_if;

    // Request held until granted
    logic                             req;
    // Same cycle grant, low whenever the host writes
    logic                             gnt;
    // Full XR bus address of the write
    logic [copper_pkg::XR_ADDR_W-1:0] addr;
    logic [copper_pkg::DATA_W-1:0]    data;

    modport requester (
        output req,
        output addr,
        output data,
        input  gnt
    );

    modport arbiter (
        input  req,
        input  addr,
        input  data,
        output gnt
    );

endinterface

// ==== copper/copper_core.sv ====
//--------------------------------------------------------------------------
// Copper core: control register, fetch/execute FSM and beam compare.
// Runs a WAIT/SKIP/JMP/MOVE program from copper memory each frame
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module copper_core (
    input  logic                              clk,
    input  logic                              copp_reset,
    xr_wr_if.requester                        xr_wr,
    input  copper_pkg::xr_wr_t                bus_i,
    output logic [copper_pkg::PC_W-1:0]       prog_addr_o,
    input  logic [copper_pkg::DATA_W-1:0]     prog_data_i,
    input  logic [copper_pkg::POS_W-1:0]      h_count_i,
    input  logic [copper_pkg::POS_W-1:0]      v_count_i
);

    // Control register state
    logic                          copper_en;
    logic [copper_pkg::PC_W-1:0]   init_pc;

    // Program counter and FSM
    logic [copper_pkg::PC_W-1:0]   pc;
    copper_pkg::copper_state_t     state;

    // Both instruction words, first word in the top half
    logic [2*copper_pkg::DATA_W-1:0] insn;

    // Decoded fields
    copper_pkg::insn_op_t          op;
    logic [copper_pkg::POS_W-1:0]  insn_y;
    logic [copper_pkg::POS_W-1:0]  insn_x;
    logic                          ignore_v;
    logic                          ignore_h;
    logic                          beam_ok;
    logic                          wait_done;
    logic                          is_move;
    logic [copper_pkg::XR_ADDR_W-1:0] move_addr;

    logic                          ctrl_wr;
    logic                          frame_restart;

    // Control register write seen on the XR bus, from the host or a MOVER
    assign ctrl_wr = bus_i.wr_en && (bus_i.addr == copper_pkg::XR_COPP_CTRL);

    // Restart strobe near the end of the last line of the frame
    assign frame_restart =
        (h_count_i == copper_pkg::POS_W'(copper_pkg::H_TOTAL - copper_pkg::RESTART_H_OFFSET)) &&
        (v_count_i == copper_pkg::POS_W'(copper_pkg::V_TOTAL - 1));

    // Field split
    // Word 1 holds the opcode and Y or address, word 2 holds X and flags or data
    assign op       = copper_pkg::insn_op_t'(insn[31:28]);
    assign insn_y   = insn[16 +: copper_pkg::POS_W];
    assign insn_x   = insn[4 +: copper_pkg::POS_W];
    assign ignore_v = insn[copper_pkg::FLAG_IGNORE_V];
    assign ignore_h = insn[copper_pkg::FLAG_IGNORE_H];

    // Beam reached when every coordinate still compared is at or past its field
    assign beam_ok = (ignore_v || (v_count_i >= insn_y)) &&
                     (ignore_h || (h_count_i >= insn_x));

    // WAIT with both coordinates ignored never ends, so it waits for the frame restart
    assign wait_done = beam_ok && !(ignore_v && ignore_h);

    // MOVE target address on the XR bus
    always_comb begin
        is_move   = 1'b1;
        move_addr = '0;
        case (op)
            // XR register, byte index only
            copper_pkg::OP_MOVER: begin
                move_addr = {{(copper_pkg::XR_ADDR_W - 8){1'b0}}, insn[23:16]};
            end
            // Color memory entry
            copper_pkg::OP_MOVEP: begin
                move_addr = {copper_pkg::XR_COLOR_MEM[copper_pkg::XR_ADDR_W-1:8],
                             insn[23:16]};
            end
            // Copper memory word, self modifying programs go through here
            copper_pkg::OP_MOVEC: begin
                move_addr = {copper_pkg::XR_COPPER_MEM[copper_pkg::XR_ADDR_W-1:copper_pkg::PC_W],
                             insn[16 +: copper_pkg::PC_W]};
            end
            default: begin
                is_move = 1'b0;
            end
        endcase
    end

    // Request only while a MOVE sits in EXEC and nothing is about to restart the core
    assign xr_wr.req  = copper_en && (state == copper_pkg::ST_EXEC) && is_move &&
                        !frame_restart && !ctrl_wr;
    assign xr_wr.addr = move_addr;
    assign xr_wr.data = insn[copper_pkg::DATA_W-1:0];

    // Copper memory is always read at the PC
    assign prog_addr_o = pc;

    // Instruction latch
    // Data from memory lags the address by one cycle
    always_ff @(posedge clk) begin
        if (state == copper_pkg::ST_LATCH1) begin
            insn[2*copper_pkg::DATA_W-1:copper_pkg::DATA_W] <= prog_data_i;
        end
        if (state == copper_pkg::ST_LATCH2) begin
            insn[copper_pkg::DATA_W-1:0] <= prog_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en <= 1'b0;
            init_pc   <= '0;
            pc        <= '0;
            state     <= copper_pkg::ST_INIT;
        end else if (ctrl_wr) begin
            // New control value restarts the program at its initial PC
            copper_en <= bus_i.data[copper_pkg::CTRL_EN_BIT];
            init_pc   <= bus_i.data[copper_pkg::PC_W-1:0];
            pc        <= bus_i.data[copper_pkg::PC_W-1:0];
            state     <= copper_pkg::ST_INIT;
        end else if (frame_restart) begin
            // Frame restart overrides whatever is executing
            pc    <= init_pc;
            state <= copper_pkg::ST_INIT;
        end else if (copper_en) begin
            case (state)
                copper_pkg::ST_INIT: begin
                    state <= copper_pkg::ST_WAIT;
                end
                copper_pkg::ST_WAIT: begin
                    // Word 1 address already presented, move on to word 2
                    pc    <= pc + 1'b1;
                    state <= copper_pkg::ST_LATCH1;
                end
                copper_pkg::ST_LATCH1: begin
                    state <= copper_pkg::ST_LATCH2;
                end
                copper_pkg::ST_LATCH2: begin
                    state <= copper_pkg::ST_EXEC;
                end
                copper_pkg::ST_EXEC: begin
                    // PC points at word 2 here
                    case (op)
                        copper_pkg::OP_WAIT: begin
                            // Stall in EXEC until the beam gets there
                            if (wait_done) begin
                                pc    <= pc + 1'b1;
                                state <= copper_pkg::ST_WAIT;
                            end
                        end
                        copper_pkg::OP_SKIP: begin
                            // Plus three jumps over the next two word instruction
                            pc    <= beam_ok ? pc + 2'd3 : pc + 1'b1;
                            state <= copper_pkg::ST_WAIT;
                        end
                        copper_pkg::OP_JMP: begin
                            pc    <= insn[16 +: copper_pkg::PC_W];
                            state <= copper_pkg::ST_WAIT;
                        end
                        copper_pkg::OP_MOVER,
                        copper_pkg::OP_MOVEP,
                        copper_pkg::OP_MOVEC: begin
                            // Hold the request until the arbiter lets it through
                            if (xr_wr.gnt) begin
                                pc    <= pc + 1'b1;
                                state <= copper_pkg::ST_WAIT;
                            end
                        end
                        default: begin
                            // Illegal opcode, refetch from the next word
                            pc    <= pc + 1'b1;
                            state <= copper_pkg::ST_INIT;
                        end
                    endcase
                end
                default: begin
                    state <= copper_pkg::ST_INIT;
                end
            endcase
        end
    end

endmodule

// ==== src/xr_wr_arbiter.sv ====
//--------------------------------------------------------------------------
// XR write arbiter: host and copper onto one registered write bus,
// host always wins
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module xr_wr_arbiter (
    input  logic                               clk,
    input  logic                               copp_reset,
    input  logic                               host_wr_i,
    input  logic [copper_pkg::XR_ADDR_W-1:0]   host_addr_i,
    input  logic [copper_pkg::DATA_W-1:0]      host_data_i,
    xr_wr_if.arbiter                           xr_wr,
    output copper_pkg::xr_wr_t                 bus_o
);

    copper_pkg::xr_wr_t bus_q;

    // Copper gets the bus only on cycles the host leaves free
    assign xr_wr.gnt = xr_wr.req && !host_wr_i;

    // Write enable is the only control bit on the bus
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            bus_q.wr_en <= 1'b0;
        end else begin
            bus_q.wr_en <= host_wr_i || xr_wr.gnt;
        end
    end

    // Winner's address and data, one cycle after acceptance
    always_ff @(posedge clk) begin
        if (host_wr_i) begin
            bus_q.addr <= host_addr_i;
            bus_q.data <= host_data_i;
        end else begin
            bus_q.addr <= xr_wr.addr;
            bus_q.data <= xr_wr.data;
        end
    end

    assign bus_o = bus_q;

endmodule

// ==== src/xr_ram.sv ====
//--------------------------------------------------------------------------
// Word memory on the XR bus, written inside its own address region,
// one registered read port
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module xr_ram #(
    parameter int                               ADDR_W = 8,
    parameter logic [copper_pkg::XR_ADDR_W-1:0] BASE   = copper_pkg::XR_COLOR_MEM
) (
    input  logic                            clk,
    input  copper_pkg::xr_wr_t              bus_i,
    input  logic [ADDR_W-1:0]               rd_addr_i,
    output logic [copper_pkg::DATA_W-1:0]   rd_data_o
);

    logic [copper_pkg::DATA_W-1:0] mem [2**ADDR_W];

    logic region_hit;

    // Region match on the address bits above the word index
    assign region_hit = bus_i.addr[copper_pkg::XR_ADDR_W-1:ADDR_W] ==
                        BASE[copper_pkg::XR_ADDR_W-1:ADDR_W];

    always_ff @(posedge clk) begin
        if (bus_i.wr_en && region_hit) begin
            mem[bus_i.addr[ADDR_W-1:0]] <= bus_i.data;
        end
        // Read data one cycle after the address
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== src/copper_top.sv ====
//--------------------------------------------------------------------------
// Copper top level: core, XR write arbiter, color and copper memories
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module copper_top (
    input  logic                                  clk,
    input  logic                                  copp_reset,
    input  logic                                  host_wr_i,
    input  logic [copper_pkg::XR_ADDR_W-1:0]      host_addr_i,
    input  logic [copper_pkg::DATA_W-1:0]         host_data_i,
    input  logic [copper_pkg::POS_W-1:0]          h_count_i,
    input  logic [copper_pkg::POS_W-1:0]          v_count_i,
    input  logic [copper_pkg::COLOR_ADDR_W-1:0]   color_rd_addr_i,
    output logic [copper_pkg::DATA_W-1:0]         color_rd_data_o,
    output logic                                  xr_wr_en_o,
    output logic [copper_pkg::XR_ADDR_W-1:0]      xr_wr_addr_o,
    output logic [copper_pkg::DATA_W-1:0]         xr_wr_data_o
);

    // Copper write request path
    xr_wr_if xr_wr ();

    // Registered XR bus shared by every write target
    copper_pkg::xr_wr_t          xr_bus;

    // Copper program fetch
    logic [copper_pkg::PC_W-1:0]   prog_addr;
    logic [copper_pkg::DATA_W-1:0] prog_data;

    copper_core u_core (
        .clk         (clk),
        .copp_reset  (copp_reset),
        .xr_wr       (xr_wr.requester),
        .bus_i       (xr_bus),
        .prog_addr_o (prog_addr),
        .prog_data_i (prog_data),
        .h_count_i   (h_count_i),
        .v_count_i   (v_count_i)
    );

    xr_wr_arbiter u_arbiter (
        .clk         (clk),
        .copp_reset  (copp_reset),
        .host_wr_i   (host_wr_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .xr_wr       (xr_wr.arbiter),
        .bus_o       (xr_bus)
    );

    // Palette, read port goes out to the video side
    xr_ram #(
        .ADDR_W (copper_pkg::COLOR_ADDR_W),
        .BASE   (copper_pkg::XR_COLOR_MEM)
    ) color_mem (
        .clk       (clk),
        .bus_i     (xr_bus),
        .rd_addr_i (color_rd_addr_i),
        .rd_data_o (color_rd_data_o)
    );

    // Copper program store, loaded by the host or by MOVEC
    xr_ram #(
        .ADDR_W (copper_pkg::PC_W),
        .BASE   (copper_pkg::XR_COPPER_MEM)
    ) copper_mem (
        .clk       (clk),
        .bus_i     (xr_bus),
        .rd_addr_i (prog_addr),
        .rd_data_o (prog_data)
    );

    assign xr_wr_en_o   = xr_bus.wr_en;
    assign xr_wr_addr_o = xr_bus.addr;
    assign xr_wr_data_o = xr_bus.data;

endmodule

// ==== verification/copper_tests.svh ====
//--------------------------------------------------------------------------
// Directed copper tests, one task per feature
//--------------------------------------------------------------------------
`ifndef COPPER_TESTS_SVH
`define COPPER_TESTS_SVH

task automatic test_movep();
    string tn = "test_movep";
    clear_program();
    append_insn(move_insn(copper_pkg::OP_MOVEP, 12'h012, 16'h0ABC));
    // Parks until the next frame with both coordinates ignored
    append_insn(beam_insn(copper_pkg::OP_WAIT, 11'd0, 11'd0, 2'b11));
    load_program(11'd0);
    start_copper(tn, 11'd0);
    expect_write(tn, 16'h8012, 16'h0ABC, 40);
    // Read back the palette entry after one cycle of read latency
    @(posedge clk);
    color_rd_addr_i <= 8'h12;
    @(posedge clk);
    @(negedge clk);
    check_equal(tn, 16'h0ABC, color_rd_data_o);
endtask

task automatic test_mover_ctrl();
    string tn = "test_mover_ctrl";
    clear_program();
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h02A, 16'h5A5A));
    // Control write with enable low stops the copper
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h001, 16'h0000));
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h02B, 16'h1111));
    append_insn(beam_insn(copper_pkg::OP_WAIT, 11'd0, 11'd0, 2'b11));
    load_program(11'd0);
    start_copper(tn, 11'd0);
    expect_write(tn, 16'h002A, 16'h5A5A, 40);
    expect_write(tn, copper_pkg::XR_COPP_CTRL, 16'h0000, 20);
    expect_no_write(tn, 200);
endtask

task automatic test_wait_beam();
    string tn = "test_wait_beam";
    clear_program();
    set_beam(11'd50, 11'd0);
    append_insn(beam_insn(copper_pkg::OP_WAIT, 11'd100, 11'd300, 2'b00));
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h030, 16'hBEEF));
    // Line 500 never comes, so only the X compare can end this one
    append_insn(beam_insn(copper_pkg::OP_WAIT, 11'd500, 11'd400, 2'b01));
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h031, 16'hCAFE));
    append_insn(beam_insn(copper_pkg::OP_WAIT, 11'd0, 11'd0, 2'b11));
    load_program(11'd0);
    start_copper(tn, 11'd0);
    expect_no_write(tn, 100);
    set_beam(11'd100, 11'd300);
    expect_write(tn, 16'h0030, 16'hBEEF, 20);
    // X still short of 400
    expect_no_write(tn, 20);
    set_beam(11'd0, 11'd400);
    expect_write(tn, 16'h0031, 16'hCAFE, 20);
    set_beam(11'd0, 11'd0);
endtask

task automatic test_skip_jmp();
    string       tn = "test_skip_jmp";
    logic [15:0] order [4];
    clear_program();
    // Always taken SKIP in words 0 and 1 jumps over MOVER 0x40
    append_insn(beam_insn(copper_pkg::OP_SKIP, 11'd0, 11'd0, 2'b11));
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h040, 16'h0040));
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h041, 16'h0041));
    // SKIP in words 6 and 7 fails since line 500 is not reached
    append_insn(beam_insn(copper_pkg::OP_SKIP, 11'd500, 11'd0, 2'b00));
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h042, 16'h0042));
    // Unknown opcode in words 10 and 11
    append_insn(32'hF000_0000);
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h043, 16'h0043));
    // JMP in words 14 and 15 lands on word 20
    append_insn(move_insn(copper_pkg::OP_JMP, 12'd20, 16'h0000));
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h044, 16'h0044));
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h045, 16'h0045));
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h046, 16'h0046));
    append_insn(beam_insn(copper_pkg::OP_WAIT, 11'd0, 11'd0, 2'b11));
    load_program(11'd0);
    start_copper(tn, 11'd0);
    order = '{16'h0041, 16'h0042, 16'h0043, 16'h0046};
    // Each MOVER carries its own register number as data
    foreach (order[i]) begin
        expect_write(tn, order[i], order[i], 40);
    end
    expect_no_write(tn, 40);
endtask

task automatic test_host_priority();
    string       tn = "test_host_priority";
    logic [15:0] addr_now;
    logic [15:0] data_now;
    logic [15:0] last_addr;
    logic [15:0] last_data;
    clear_program();
    append_insn(move_insn(copper_pkg::OP_MOVEP, 12'h020, 16'h1234));
    append_insn(beam_insn(copper_pkg::OP_WAIT, 11'd0, 11'd0, 2'b11));
    load_program(11'd0);
    last_addr = '0;
    last_data = '0;
    // Cycle 0 enables the copper and cycles 1 to 30 keep the host on the bus
    for (int i = 0; i <= 31; i++) begin
        addr_now = (i == 0) ? copper_pkg::XR_COPP_CTRL : 16'h8040 + 16'(i);
        data_now = (i == 0) ? 16'h8000 : 16'(i);
        @(posedge clk);
        host_wr_i   <= (i <= 30);
        host_addr_i <= addr_now;
        host_data_i <= data_now;
        @(negedge clk);
        // Bus shows the previous host cycle and never the copper
        if (i > 0) begin
            check_equal(tn, 16'h0001, {15'b0, xr_wr_en_o});
            check_equal(tn, last_addr, xr_wr_addr_o);
            check_equal(tn, last_data, xr_wr_data_o);
        end
        last_addr = addr_now;
        last_data = data_now;
    end
    expect_write(tn, 16'h8020, 16'h1234, 10);
endtask

task automatic test_frame_restart_movec();
    string tn = "test_frame_restart_movec";
    clear_program();
    // Words 16,17
    append_insn(move_insn(copper_pkg::OP_MOVER, 12'h050, 16'h1111));
    // Patches word 17 with new data for the MOVER above
    append_insn(move_insn(copper_pkg::OP_MOVEC, 12'h011, 16'h2222));
    append_insn(beam_insn(copper_pkg::OP_WAIT, 11'd0, 11'd0, 2'b11));
    load_program(11'h010);
    start_copper(tn, 11'h010);
    expect_write(tn, 16'h0050, 16'h1111, 40);
    expect_write(tn, 16'hC011, 16'h2222, 20);
    expect_no_write(tn, 20);
    // One cycle at the end of frame point
    set_beam(11'(copper_pkg::V_TOTAL - 1),
             11'(copper_pkg::H_TOTAL - copper_pkg::RESTART_H_OFFSET));
    set_beam(11'd0, 11'd0);
    expect_write(tn, 16'h0050, 16'h2222, 40);
    expect_write(tn, 16'hC011, 16'h2222, 20);
endtask

`endif

// ==== verification/copper_tb.sv ====
//--------------------------------------------------------------------------
// Copper testbench: clock, reset, DUT, bus watchers and program loader
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module copper_tb;

    logic                                clk;
    logic                                copp_reset;
    logic                                host_wr_i;
    logic [copper_pkg::XR_ADDR_W-1:0]    host_addr_i;
    logic [copper_pkg::DATA_W-1:0]       host_data_i;
    logic [copper_pkg::POS_W-1:0]        h_count_i;
    logic [copper_pkg::POS_W-1:0]        v_count_i;
    logic [copper_pkg::COLOR_ADDR_W-1:0] color_rd_addr_i;
    logic [copper_pkg::DATA_W-1:0]       color_rd_data_o;
    logic                                xr_wr_en_o;
    logic [copper_pkg::XR_ADDR_W-1:0]    xr_wr_addr_o;
    logic [copper_pkg::DATA_W-1:0]       xr_wr_data_o;

    // Program image of the current test with two words per instruction
    logic [15:0] prog_words[$];

    copper_top dut (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .host_wr_i       (host_wr_i),
        .host_addr_i     (host_addr_i),
        .host_data_i     (host_data_i),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .color_rd_addr_i (color_rd_addr_i),
        .color_rd_data_o (color_rd_data_o),
        .xr_wr_en_o      (xr_wr_en_o),
        .xr_wr_addr_o    (xr_wr_addr_o),
        .xr_wr_data_o    (xr_wr_data_o)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display(">>> FAIL");
        $display("%s", msg);
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    // WAIT and SKIP keep Y in word 1 and X with the ignore flags in word 2
    function automatic logic [31:0] beam_insn(input logic [3:0] op, input logic [10:0] y,
                                              input logic [10:0] x, input logic [1:0] flags);
        return {op, 1'b0, y, 1'b0, x, 2'b00, flags};
    endfunction

    // MOVE and JMP put a 12 bit target after the opcode and data in word 2
    function automatic logic [31:0] move_insn(input logic [3:0] op, input logic [11:0] target,
                                              input logic [15:0] data);
        return {op, target, data};
    endfunction

    task automatic append_insn(input logic [31:0] insn);
        prog_words.push_back(insn[31:16]);
        prog_words.push_back(insn[15:0]);
    endtask

    task automatic host_write(input logic [15:0] addr, input logic [15:0] data);
        @(posedge clk);
        host_wr_i   <= 1'b1;
        host_addr_i <= addr;
        host_data_i <= data;
        @(posedge clk);
        host_wr_i   <= 1'b0;
    endtask

    task automatic set_beam(input logic [10:0] v, input logic [10:0] h);
        @(posedge clk);
        v_count_i <= v;
        h_count_i <= h;
    endtask

    // One word per cycle into copper memory
    task automatic load_program(input logic [10:0] offset);
        foreach (prog_words[i]) begin
            @(posedge clk);
            host_wr_i   <= 1'b1;
            host_addr_i <= copper_pkg::XR_COPPER_MEM + 16'(offset) + 16'(i);
            host_data_i <= prog_words[i];
        end
        @(posedge clk);
        host_wr_i <= 1'b0;
    endtask

    // Disable the copper before a new program goes in
    task automatic clear_program();
        host_write(copper_pkg::XR_COPP_CTRL, 16'h0000);
        prog_words.delete();
    endtask

    // Next bus write of any source must match address and data
    task automatic expect_write(input string name, input logic [15:0] addr,
                                input logic [15:0] data, input int max_cycles);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < max_cycles && !seen; i++) begin
            @(negedge clk);
            seen = xr_wr_en_o;
        end
        if (!seen) begin
            abort_run($sformatf("%s: no bus write within %0d cycles", name, max_cycles));
        end else begin
            check_equal(name, addr, xr_wr_addr_o);
            check_equal(name, data, xr_wr_data_o);
        end
    endtask

    task automatic expect_no_write(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (xr_wr_en_o) begin
                abort_run($sformatf("%s: unexpected bus write to %h", name, xr_wr_addr_o));
            end
        end
    endtask

    // Enable write shows up on the bus right after the host cycle
    task automatic start_copper(input string name, input logic [10:0] pc);
        host_write(copper_pkg::XR_COPP_CTRL, {1'b1, 4'b0000, pc});
        expect_write(name, copper_pkg::XR_COPP_CTRL, {1'b1, 4'b0000, pc}, 2);
    endtask

    `include "copper_tests.svh"

    initial begin
        copp_reset      <= 1'b1;
        host_wr_i       <= 1'b0;
        host_addr_i     <= '0;
        host_data_i     <= '0;
        h_count_i       <= '0;
        v_count_i       <= '0;
        color_rd_addr_i <= '0;
        repeat (5) @(posedge clk);
        copp_reset <= 1'b0;
        // Bus write enable comes out of reset low
        @(negedge clk);
        check_equal("reset", 16'h0000, {15'b0, xr_wr_en_o});
        test_movep();
        test_mover_ctrl();
        test_wait_beam();
        test_skip_jmp();
        test_host_priority();
        test_frame_restart_movec();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verification
common/copper_pkg.sv
common/xr_wr_if.sv
copper/copper_core.sv
src/xr_wr_arbiter.sv
src/xr_ram.sv
src/copper_top.sv
verification/copper_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the copper testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module copper_tb \
    -o copper_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/copper_sim > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; } || exit 0
